/* rtl/qsic_defs.svh */
/*
 * register offsets, reply settle delay and disk-pack load table contents
 */
`ifndef QSIC_DEFS_SVH
`define QSIC_DEFS_SVH

// i/o page offsets, only decoded with bs7 set
`define QSIC_REG_CONFIG  13'o17720  // indicator panel list/count
`define QSIC_REG_BLOCK   13'o17722  // drive select + block number
`define QSIC_REG_LBA_LO  13'o17724  // read only
`define QSIC_REG_LBA_HI  13'o17726  // read only
`define QSIC_REG_STATUS  13'o17730  // read only

// clocks from driving the transceivers to rply, lets the cable settle
`define QSIC_SETTLE_CYCLES 2

// load table, one entry per drive
`define QSIC_PACKS 8

// entry layout {enable, device, lba offset}
// device codes: 0 sd0, 1 sd1, 2 ramdisk, 3 usb
`define QSIC_PACK0 {1'b1, 2'd0, 32'h0002_0000}
`define QSIC_PACK1 {1'b1, 2'd2, 32'h0000_0000}
`define QSIC_PACK2 {1'b0, 2'd0, 32'h0002_4000}
`define QSIC_PACK3 {1'b0, 2'd0, 32'h0002_6000}
`define QSIC_PACK4 {1'b0, 2'd0, 32'h0002_8000}
`define QSIC_PACK5 {1'b0, 2'd0, 32'h0002_a000}
`define QSIC_PACK6 {1'b0, 2'd0, 32'h0002_c000}
`define QSIC_PACK7 {1'b0, 2'd0, 32'h0002_e000}

`endif

/* rtl/qbus_pkg.sv */
/*
 * qbus side types: raw and synchronized strobes, register select,
 * write data word views and reply sequencer states
 */
package qbus_pkg;

   typedef struct packed {
      logic sync;
      logic din;
      logic dout;
      logic init;
   } bus_strobe_t;  // straight from the receivers

   typedef struct packed {
      logic sync;       // levels, two clocks late
      logic din;
      logic dout;
      logic sync_rise;  // single clock pulses
      logic din_rise;
      logic dout_rise;
      logic init;
   } sync_strobe_t;

   typedef enum logic [2:0] {
      sel_none,
      sel_config,
      sel_block,
      sel_lba_lo,
      sel_lba_hi,
      sel_status
   } reg_sel_t;

   // indicator panel config layout, one spare bit between fields
   typedef struct packed {
      logic [1:0] rsv_hi;
      logic [1:0] count;   // 13:12
      logic       rsv11;
      logic [1:0] list3;   // 10:9
      logic       rsv8;
      logic [1:0] list2;   // 7:6
      logic       rsv5;
      logic [1:0] list1;   // 4:3
      logic       rsv2;
      logic [1:0] list0;   // 1:0
   } cfg_view_t;

   typedef struct packed {
      logic [2:0]  drive;  // 15:13
      logic [12:0] block;  // 12:0
   } blk_view_t;

   // same data word, decoded per target register
   typedef union packed {
      cfg_view_t cfg_view;
      blk_view_t blk_view;
   } dal_word_u;

   typedef enum logic [1:0] {
      st_idle,
      st_settle,  // transceivers on, waiting for cable
      st_drive,   // data out, rply up
      st_ack      // write acknowledged
   } reply_state_t;

endpackage

/* rtl/storage_pkg.sv */
/*
 * storage side types: device codes, load table entry, block request
 */
`include "qsic_defs.svh"

package storage_pkg;

   typedef enum logic [1:0] {
      dev_sd0     = 2'd0,
      dev_sd1     = 2'd1,
      dev_ramdisk = 2'd2,
      dev_usb     = 2'd3
   } dev_code_t;

   typedef struct packed {
      logic        enable;  // pack is mounted
      dev_code_t   dev;     // where it lives
      logic [31:0] offset;  // first lba of the pack on that device
   } pack_entry_t;

   typedef struct packed {
      dev_code_t   dev;
      logic [31:0] lba;
   } block_req_t;

   // one bit per table entry
   typedef logic [`QSIC_PACKS-1:0] pack_mask_t;

endpackage

/* rtl/qbus_sync.sv */
/*
 * bus strobe synchronizers with rising edge pulses
 */
`timescale 1ns/1ps

module qbus_sync import qbus_pkg::*; (
   input  logic         clk20,
   input  logic         rst_n,
   input  bus_strobe_t  bus,
   output sync_strobe_t strobes
);

   logic [2:0] sync_sr;  // [1] is the usable level, [2] the previous one
   logic [2:0] din_sr;
   logic [2:0] dout_sr;
   logic [1:0] init_sr;  // no edge needed, level only
   logic [2:0] pulses;

   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         sync_sr <= '0;
         din_sr  <= '0;
         dout_sr <= '0;
         init_sr <= '0;
      end else begin
         sync_sr <= {sync_sr[1:0], bus.sync};
         din_sr  <= {din_sr[1:0], bus.din};
         dout_sr <= {dout_sr[1:0], bus.dout};
         init_sr <= {init_sr[0], bus.init};
      end
   end

   assign strobes = '{
      sync:      sync_sr[1],
      din:       din_sr[1],
      dout:      dout_sr[1],
      sync_rise: sync_sr[1] & ~sync_sr[2],
      din_rise:  din_sr[1] & ~din_sr[2],
      dout_rise: dout_sr[1] & ~dout_sr[2],
      init:      init_sr[1]
   };

   assign pulses = {strobes.sync_rise, strobes.din_rise, strobes.dout_rise};

   // downstream logic counts on a rise being seen exactly once
   a_pulse_one_cycle: assert property (@(posedge clk20) disable iff (!rst_n)
      (pulses != 3'b000) |=> ((pulses & $past(pulses)) == 3'b000));

endmodule

/* rtl/reg_select.sv */
/*
 * address phase capture, register decode and read data multiplexer
 */
`timescale 1ns/1ps
`include "qsic_defs.svh"

module reg_select import qbus_pkg::*, storage_pkg::*; (
   input  logic         clk20,
   input  logic         rst_n,
   input  sync_strobe_t strobes,
   input  logic [21:0]  dal_in,
   input  logic         bs7,
   input  logic [15:0]  cfg_word,
   input  dal_word_u    block_word,
   input  block_req_t   req,
   input  logic [15:0]  status_word,
   output reg_sel_t     sel,
   output dal_word_u    wdata,
   output logic [21:0]  dal_out
);

   logic [12:0] addr_q;  // i/o page offset, upper bits don't matter here
   logic        bs7_q;
   logic        cyc_vld;  // address captured for this sync

   // grab the address when sync comes up
   always_ff @(posedge clk20) begin
      if (strobes.sync_rise) begin
         addr_q <= dal_in[12:0];
         bs7_q  <= bs7;
      end
      if (strobes.dout_rise)
         wdata <= dal_in[15:0];  // data phase of a DATO
   end

   always_ff @(posedge clk20) begin
      if (!rst_n)
         cyc_vld <= 1'b0;
      else if (strobes.sync_rise)
         cyc_vld <= 1'b1;
      else if (!strobes.sync)
         cyc_vld <= 1'b0;  // bus cycle over
   end

   always_comb begin
      sel = sel_none;
      if (cyc_vld && strobes.sync && bs7_q) begin
         case (addr_q)
            `QSIC_REG_CONFIG: sel = sel_config;
            `QSIC_REG_BLOCK:  sel = sel_block;
            `QSIC_REG_LBA_LO: sel = sel_lba_lo;
            `QSIC_REG_LBA_HI: sel = sel_lba_hi;
            `QSIC_REG_STATUS: sel = sel_status;
            default:          sel = sel_none;  // not ours
         endcase
      end
   end

   // read back, zero extended onto the 22 bit bus
   always_comb begin
      case (sel)
         sel_config: dal_out = {6'b0, cfg_word};
         sel_block:  dal_out = {6'b0, block_word};
         sel_lba_lo: dal_out = {6'b0, req.lba[15:0]};
         sel_lba_hi: dal_out = {6'b0, req.lba[31:16]};
         sel_status: dal_out = {6'b0, status_word};
         default:    dal_out = '0;
      endcase
   end

endmodule

/* rtl/slave_fsm.sv */
/*
 * reply sequencer for DATI and DATO slave cycles
 */
`timescale 1ns/1ps

module slave_fsm import qbus_pkg::*; (
   input  logic         clk20,
   input  logic         rst_n,
   input  sync_strobe_t strobes,
   input  reg_sel_t     sel,
   input  logic         done,
   output logic         start,
   output logic         wr_stb,
   output logic         dal_tx,
   output logic         dal_be_n,
   output logic         dal_st,
   output logic         rply
);

   reply_state_t state;
   logic         hit;

   assign hit   = (sel != sel_none);
   assign start = (state == st_idle) && hit && strobes.din_rise;  // kick the settle timer

   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         state    <= st_idle;
         wr_stb   <= 1'b0;
         dal_tx   <= 1'b0;
         dal_be_n <= 1'b1;
         dal_st   <= 1'b0;
         rply     <= 1'b0;
      end else begin
         wr_stb <= 1'b0;  // single clock
         case (state)
            st_idle: begin
               if (hit && strobes.din_rise) begin
                  state  <= st_settle;
                  dal_tx <= 1'b1;  // turn transceivers around first
               end else if (hit && strobes.dout_rise) begin
                  state  <= st_ack;
                  wr_stb <= 1'b1;  // wdata is valid next clock
                  rply   <= 1'b1;
               end
            end
            st_settle: begin
               if (!strobes.din) begin
                  state  <= st_idle;  // master gave up
                  dal_tx <= 1'b0;
               end else if (done) begin
                  state    <= st_drive;
                  rply     <= 1'b1;
                  dal_st   <= 1'b1;  // latch read data
                  dal_be_n <= 1'b0;
               end
            end
            st_drive: begin
               if (!strobes.din) begin
                  state    <= st_idle;
                  dal_tx   <= 1'b0;
                  dal_be_n <= 1'b1;
                  dal_st   <= 1'b0;
                  rply     <= 1'b0;
               end
            end
            st_ack: begin
               if (!strobes.dout) begin
                  state <= st_idle;
                  rply  <= 1'b0;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // data must be on the bus whenever a read is acknowledged
   a_rply_drives_bus: assert property (@(posedge clk20) disable iff (!rst_n)
      (state == st_drive && rply) |-> (!dal_be_n && dal_tx));

endmodule

/* rtl/settle_timer.sv */
/*
 * settle delay counter between transceiver turnaround and read reply
 */
`timescale 1ns/1ps
`include "qsic_defs.svh"

module settle_timer (
   input  logic clk20,
   input  logic rst_n,
   input  logic start,
   output logic done
);

   localparam int CNT_W = $clog2(`QSIC_SETTLE_CYCLES + 1);

   logic [CNT_W-1:0] cnt;
   logic             armed;

   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         cnt   <= '0;
         armed <= 1'b0;
      end else if (start) begin
         cnt   <= CNT_W'(`QSIC_SETTLE_CYCLES - 1);  // start cycle counts as one
         armed <= 1'b1;
      end else if (armed) begin
         if (cnt == '0)
            armed <= 1'b0;
         else
            cnt <= cnt - 1'b1;
      end
   end

   assign done = armed && (cnt == '0);  // one clock pulse

endmodule

/* rtl/ip_config_reg.sv */
/*
 * indicator panel configuration, four panel selects and a panel count
 */
`timescale 1ns/1ps

module ip_config_reg import qbus_pkg::*; (
   input  logic        clk20,
   input  logic        rst_n,
   input  reg_sel_t    sel,
   input  logic        wr_stb,
   input  dal_word_u   wdata,
   output logic [15:0] cfg_word
);

   dal_word_u cfg_q;  // spare bits never written, read as zero

   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         // default shows qbus, rk, lamptest, rk with three panels
         cfg_q.cfg_view <= '{count: 2'd2, list3: 2'd1, list2: 2'd0,
                             list1: 2'd1, list0: 2'd2, default: '0};
      end else if (wr_stb && sel == sel_config) begin
         cfg_q.cfg_view <= '{count: wdata.cfg_view.count,
                             list3: wdata.cfg_view.list3,
                             list2: wdata.cfg_view.list2,
                             list1: wdata.cfg_view.list1,
                             list0: wdata.cfg_view.list0,
                             default: '0};
      end
   end

   assign cfg_word = cfg_q;

endmodule

/* rtl/pack_table.sv */
/*
 * block register, disk-pack load table lookup, lba offset add and
 * loaded mask for the status register
 */
`timescale 1ns/1ps
`include "qsic_defs.svh"

module pack_table import qbus_pkg::*, storage_pkg::*; (
   input  logic         clk20,
   input  logic         rst_n,
   input  sync_strobe_t strobes,
   input  reg_sel_t     sel,
   input  logic         wr_stb,
   input  dal_word_u    wdata,
   input  logic [3:0]   dev_ready,  // indexed by dev_code_t
   output dal_word_u    block_word,
   output block_req_t   req,
   output logic [15:0]  status_word
);

   // fixed for now, one entry per drive select
   localparam pack_entry_t LOAD_TABLE [`QSIC_PACKS] = '{
      `QSIC_PACK0, `QSIC_PACK1, `QSIC_PACK2, `QSIC_PACK3,
      `QSIC_PACK4, `QSIC_PACK5, `QSIC_PACK6, `QSIC_PACK7
   };

   dal_word_u   blk_q;
   pack_entry_t entry;   // entry for the selected drive
   pack_mask_t  loaded;

   always_ff @(posedge clk20) begin
      if (!rst_n)
         blk_q <= '0;
      else if (strobes.init)
         blk_q <= '0;  // bus init clears the drive/block
      else if (wr_stb && sel == sel_block)
         blk_q <= wdata;
   end

   assign entry = LOAD_TABLE[blk_q.blk_view.drive];

   assign req.dev = entry.dev;
   assign req.lba = {19'b0, blk_q.blk_view.block} + entry.offset;  // offset into the pack

   // loaded when mounted and the backing device says ready
   always_comb begin
      for (int i = 0; i < `QSIC_PACKS; i++)
         loaded[i] = LOAD_TABLE[i].enable & dev_ready[LOAD_TABLE[i].dev];
   end

   assign block_word  = blk_q;
   assign status_word = {5'b0, entry.dev, entry.enable, loaded};

   // lba must never wrap below the start of its pack
   a_lba_in_pack: assert property (@(posedge clk20) disable iff (!rst_n)
      req.lba >= entry.offset);

endmodule

/* rtl/qsic_slave.sv */
/*
 * qbus slave register block top level
 */
`timescale 1ns/1ps

module qsic_slave import qbus_pkg::*, storage_pkg::*; (
   input  logic        clk20,
   input  logic        rst_n,
   input  bus_strobe_t bus,
   input  logic [21:0] dal_in,
   input  logic        bs7,
   input  logic [3:0]  dev_ready,
   output logic [21:0] dal_out,
   output logic        dal_tx,
   output logic        dal_be_n,
   output logic        dal_st,
   output logic        rply,
   output block_req_t  req
);

   sync_strobe_t strobes;
   reg_sel_t     sel;
   dal_word_u    wdata;
   dal_word_u    block_word;
   logic [15:0]  cfg_word;
   logic [15:0]  status_word;
   logic         wr_stb;
   logic         start;   // settle timer handshake
   logic         done;

   qbus_sync qbus_sync_inst (.clk20, .rst_n, .bus, .strobes);

   reg_select reg_select_inst (
      .clk20, .rst_n, .strobes, .dal_in, .bs7, .cfg_word, .block_word,
      .req, .status_word, .sel, .wdata, .dal_out
   );

   slave_fsm slave_fsm_inst (
      .clk20, .rst_n, .strobes, .sel, .done, .start, .wr_stb,
      .dal_tx, .dal_be_n, .dal_st, .rply
   );

   settle_timer settle_timer_inst (.clk20, .rst_n, .start, .done);

   ip_config_reg ip_config_reg_inst (.clk20, .rst_n, .sel, .wr_stb, .wdata, .cfg_word);

   pack_table pack_table_inst (
      .clk20, .rst_n, .strobes, .sel, .wr_stb, .wdata, .dev_ready,
      .block_word, .req, .status_word
   );

endmodule

/* tb/tb_qsic_slave.sv */
/*
 * testbench for the qbus slave register block: clock, reset, stimulus
 * table, bus read/write tasks, random block words and status patterns
 */
`timescale 1ns/1ps
`include "qsic_defs.svh"

module tb_qsic_slave
   import qbus_pkg::*, storage_pkg::*;
();

   localparam int RPLY_TIMEOUT   = 50;  // clocks
   localparam int NOREPLY_CYCLES = 30;  // how long a silent slave is watched
   localparam int ADDR_HOLD      = 4;   // sync is seen two clocks late
   localparam int IDLE_GAP       = 4;
   localparam int NUM_STIM       = 24;
   localparam int NUM_RAND       = 12;

   typedef enum logic [1:0] {op_read, op_write, op_noreply, op_init} op_t;

   typedef struct packed {
      op_t         op;
      logic [12:0] offset;
      logic        bs7;
      logic [15:0] wdata;
      logic [15:0] exp;  // expected read data
   } stim_t;

   // load table as {enable, device, offset}, same layout as the header
   localparam logic [34:0] PACKS [`QSIC_PACKS] = '{
      `QSIC_PACK0, `QSIC_PACK1, `QSIC_PACK2, `QSIC_PACK3,
      `QSIC_PACK4, `QSIC_PACK5, `QSIC_PACK6, `QSIC_PACK7
   };

   localparam stim_t STIM [NUM_STIM] = '{
      '{op_read,    `QSIC_REG_CONFIG, 1'b1, 16'h0000, 16'h220a},  // reset values
      '{op_read,    `QSIC_REG_BLOCK,  1'b1, 16'h0000, 16'h0000},
      '{op_read,    `QSIC_REG_LBA_LO, 1'b1, 16'h0000, 16'h0000},  // drive 0 at 0002_0000
      '{op_read,    `QSIC_REG_LBA_HI, 1'b1, 16'h0000, 16'h0002},
      '{op_write,   `QSIC_REG_CONFIG, 1'b1, 16'hffff, 16'h0000},
      '{op_read,    `QSIC_REG_CONFIG, 1'b1, 16'h0000, 16'h36db},  // only the five fields
      '{op_write,   `QSIC_REG_CONFIG, 1'b1, 16'h0000, 16'h0000},
      '{op_read,    `QSIC_REG_CONFIG, 1'b1, 16'h0000, 16'h0000},
      '{op_write,   `QSIC_REG_CONFIG, 1'b1, 16'ha5a5, 16'h0000},
      '{op_read,    `QSIC_REG_CONFIG, 1'b1, 16'h0000, 16'h2481},
      '{op_write,   `QSIC_REG_CONFIG, 1'b1, 16'h1234, 16'h0000},
      '{op_read,    `QSIC_REG_CONFIG, 1'b1, 16'h0000, 16'h1210},
      '{op_noreply, `QSIC_REG_CONFIG, 1'b0, 16'h0000, 16'h0000},  // not the i/o page
      '{op_noreply, 13'o17732,        1'b1, 16'h0000, 16'h0000},  // unused offsets
      '{op_noreply, 13'o17716,        1'b1, 16'h0000, 16'h0000},
      '{op_write,   `QSIC_REG_BLOCK,  1'b1, 16'h2005, 16'h0000},  // drive 1, block 5
      '{op_read,    `QSIC_REG_BLOCK,  1'b1, 16'h0000, 16'h2005},
      '{op_write,   `QSIC_REG_LBA_LO, 1'b1, 16'hbeef, 16'h0000},  // read only
      '{op_read,    `QSIC_REG_LBA_LO, 1'b1, 16'h0000, 16'h0005},
      '{op_read,    `QSIC_REG_LBA_HI, 1'b1, 16'h0000, 16'h0000},  // ramdisk offset 0
      '{op_init,    13'o0,            1'b0, 16'h0000, 16'h0000},
      '{op_read,    `QSIC_REG_BLOCK,  1'b1, 16'h0000, 16'h0000},  // cleared by init
      '{op_read,    `QSIC_REG_CONFIG, 1'b1, 16'h0000, 16'h1210},  // survives init
      '{op_read,    `QSIC_REG_LBA_HI, 1'b1, 16'h0000, 16'h0002}
   };

   // drives 0, 1 and 5 cover sd0, ramdisk and a disabled entry
   localparam logic [15:0] STATUS_BLK [3] = '{16'h0000, 16'h2000, 16'ha000};
   localparam logic [3:0]  READY_PAT  [6] = '{4'b0000, 4'b0001, 4'b0100,
                                              4'b0101, 4'b1111, 4'b1010};

   logic        clk20;
   logic        rst_n;
   bus_strobe_t bus;
   logic [21:0] dal_in;
   logic        bs7;
   logic [3:0]  dev_ready;
   logic [21:0] dal_out;
   logic        dal_tx;
   logic        dal_be_n;
   logic        dal_st;
   logic        rply;
   block_req_t  req;

   integer seed;
   int     err_cnt = 0;

   qsic_slave qsic_slave_inst (
      .clk20, .rst_n, .bus, .dal_in, .bs7, .dev_ready,
      .dal_out, .dal_tx, .dal_be_n, .dal_st, .rply, .req
   );

   initial begin
      clk20 = 1'b0;
      forever #10 clk20 = ~clk20;  // 50 MHz nominal, 20 ns
   end

   task automatic report_fail();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
         report_fail();
      end
   endtask

   // outputs are registered on the rising edge, so look at them on the falling one
   task automatic wait_rply(input logic level);
      int n;
      n = 0;
      @(negedge clk20);
      while (rply !== level && n < RPLY_TIMEOUT) begin
         @(negedge clk20);
         n++;
      end
      if (rply !== level) begin
         $display("timeout: rply did not go to %0d within %0d clocks", level, RPLY_TIMEOUT);
         report_fail();
      end
   endtask

   // read reply, counting the clocks dal_tx leads rply by
   task automatic wait_read_rply(output int tx_lead);
      int n;
      n       = 0;
      tx_lead = 0;
      @(negedge clk20);
      while (rply !== 1'b1 && n < RPLY_TIMEOUT) begin
         if (dal_tx === 1'b1)
            tx_lead++;  // transceivers on, cable settling
         @(negedge clk20);
         n++;
      end
      if (rply !== 1'b1) begin
         $display("timeout: rply did not go to 1 within %0d clocks", RPLY_TIMEOUT);
         report_fail();
      end
   endtask

   task automatic addr_phase(input logic [12:0] offset, input logic bs7_v);
      @(posedge clk20);
      dal_in <= {9'b0, offset};
      bs7    <= bs7_v;
      @(posedge clk20);
      bus.sync <= 1'b1;
      repeat (ADDR_HOLD) @(posedge clk20);  // slave latches on its sync rise
      dal_in <= '0;
      bs7    <= 1'b0;
   endtask

   task automatic end_cycle();
      @(posedge clk20);
      bus.sync <= 1'b0;
      dal_in   <= '0;
      repeat (IDLE_GAP) @(posedge clk20);  // let sync fall through the synchronizer
   endtask

   task automatic bus_read(input logic [12:0] offset, input logic bs7_v,
                           output logic [15:0] data);
      int tx_lead;
      addr_phase(offset, bs7_v);
      @(posedge clk20);
      bus.din <= 1'b1;
      wait_read_rply(tx_lead);
      check("dal_tx to rply", 32'(tx_lead), 32'(`QSIC_SETTLE_CYCLES));
      data = dal_out[15:0];
      check("dal_out[21:16]", 32'(dal_out[21:16]), 32'h0);  // zero extended
      check("dal_tx", 32'(dal_tx), 32'h1);
      check("dal_st", 32'(dal_st), 32'h1);
      check("dal_be_n", 32'(dal_be_n), 32'h0);
      @(posedge clk20);
      bus.din <= 1'b0;
      wait_rply(1'b0);
      check("dal_tx", 32'(dal_tx), 32'h0);  // all back to idle with rply
      check("dal_st", 32'(dal_st), 32'h0);
      check("dal_be_n", 32'(dal_be_n), 32'h1);
      end_cycle();
   endtask

   task automatic bus_write(input logic [12:0] offset, input logic bs7_v,
                            input logic [15:0] data);
      addr_phase(offset, bs7_v);
      @(posedge clk20);
      dal_in <= {6'b0, data};
      @(posedge clk20);
      bus.dout <= 1'b1;  // data already stable
      wait_rply(1'b1);
      check("dal_tx", 32'(dal_tx), 32'h0);  // a write never turns the bus around
      @(posedge clk20);
      bus.dout <= 1'b0;
      wait_rply(1'b0);
      end_cycle();
   endtask

   task automatic noreply_read(input logic [12:0] offset, input logic bs7_v);
      addr_phase(offset, bs7_v);
      @(posedge clk20);
      bus.din <= 1'b1;
      for (int n = 0; n < NOREPLY_CYCLES; n++) begin
         @(negedge clk20);
         check("rply", 32'(rply), 32'h0);
         check("dal_tx", 32'(dal_tx), 32'h0);
      end
      @(posedge clk20);
      bus.din <= 1'b0;
      end_cycle();
   endtask

   task automatic init_pulse();
      @(posedge clk20);
      bus.init <= 1'b1;
      repeat (4) @(posedge clk20);  // long enough for the two stage synchronizer
      bus.init <= 1'b0;
      repeat (IDLE_GAP) @(posedge clk20);
   endtask

   // lba is the block number plus the offset of the drive's table entry
   function automatic logic [31:0] expected_lba(input logic [15:0] blk);
      logic [34:0] ent;
      ent = PACKS[blk[15:13]];
      return 32'(blk[12:0]) + ent[31:0];
   endfunction

   function automatic logic [15:0] expected_status(input logic [2:0] drive,
                                                   input logic [3:0] ready);
      logic [7:0]  mask;
      logic [34:0] ent;
      for (int i = 0; i < `QSIC_PACKS; i++) begin
         ent     = PACKS[i];
         mask[i] = ent[34] & ready[ent[33:32]];  // mounted and device ready
      end
      ent = PACKS[drive];
      return {5'b0, ent[33:32], ent[34], mask};
   endfunction

   initial begin
      logic [15:0] rd;
      logic [31:0] rnd;
      logic [15:0] blk;
      logic [31:0] lba_exp;
      seed      = 32'h1656;
      rst_n     = 1'b0;
      bus       = '0;
      dal_in    = '0;
      bs7       = 1'b0;
      dev_ready = 4'b0101;
      repeat (5) @(posedge clk20);
      rst_n <= 1'b1;
      @(negedge clk20);
      check("dal_tx", 32'(dal_tx), 32'h0);
      check("dal_st", 32'(dal_st), 32'h0);
      check("rply", 32'(rply), 32'h0);
      check("dal_be_n", 32'(dal_be_n), 32'h1);

      for (int i = 0; i < NUM_STIM; i++) begin
         case (STIM[i].op)
            op_read: begin
               bus_read(STIM[i].offset, STIM[i].bs7, rd);
               check("dal_out", 32'(rd), 32'(STIM[i].exp));
            end
            op_write:   bus_write(STIM[i].offset, STIM[i].bs7, STIM[i].wdata);
            op_noreply: noreply_read(STIM[i].offset, STIM[i].bs7);
            default:    init_pulse();
         endcase
      end

      // random drive/block words through the load table
      for (int i = 0; i < NUM_RAND; i++) begin
         rnd     = $random(seed);
         blk     = rnd[15:0];
         lba_exp = expected_lba(blk);
         bus_write(`QSIC_REG_BLOCK, 1'b1, blk);
         @(negedge clk20);
         check("req.lba", req.lba, lba_exp);
         check("req.dev", 32'(req.dev), 32'(PACKS[blk[15:13]][33:32]));
         bus_read(`QSIC_REG_LBA_LO, 1'b1, rd);
         check("dal_out", 32'(rd), 32'(lba_exp[15:0]));
         bus_read(`QSIC_REG_LBA_HI, 1'b1, rd);
         check("dal_out", 32'(rd), 32'(lba_exp[31:16]));
      end

      foreach (STATUS_BLK[d]) begin
         bus_write(`QSIC_REG_BLOCK, 1'b1, STATUS_BLK[d]);
         foreach (READY_PAT[p]) begin
            @(posedge clk20);
            dev_ready <= READY_PAT[p];
            bus_read(`QSIC_REG_STATUS, 1'b1, rd);
            check("dal_out", 32'(rd),
                  32'(expected_status(STATUS_BLK[d][15:13], READY_PAT[p])));
         end
      end

      if (err_cnt == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         report_fail();
      end
   end

endmodule

/* flist.f */
+incdir+rtl
rtl/qbus_pkg.sv
rtl/storage_pkg.sv
rtl/qbus_sync.sv
rtl/reg_select.sv
rtl/slave_fsm.sv
rtl/settle_timer.sv
rtl/ip_config_reg.sv
rtl/pack_table.sv
rtl/qsic_slave.sv
tb/tb_qsic_slave.sv

/* Makefile */
# Verilator build and run of the qbus slave register block testbench
# pass or fail is the exit status of the simulation binary

VERILATOR ?= verilator
TOP       ?= tb_qsic_slave
FLIST     ?= flist.f
SEED      ?= 1
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) from $(FLIST) with $(VERILATOR) and run it"
	@echo "  clean  remove the build directory $(BUILD)"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR TOP FLIST SEED BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD)
